// ==== cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Width of the data bus and of A, X, Y
`define CPU_DATA_W 8

// Width of the Wishbone byte address
`define CPU_ADDR_W 16

// First instruction byte after reset
`define CPU_START_PC 16'h0200

// Entries between fetch and execute
`define CPU_UOP_DEPTH 4

// Status after reset
// I, B and the unused bit 5 set
`define CPU_P_RESET 8'h34

`endif

// ==== cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	// Supported 6502 opcodes
	// Immediate forms carry one operand byte
	typedef enum logic [7:0]
	{
		BRK     = 8'h00,
		ORA_IMM = 8'h09,
		CLC     = 8'h18,
		AND_IMM = 8'h29,
		SEC     = 8'h38,
		EOR_IMM = 8'h49,
		CLI     = 8'h58,
		ADC_IMM = 8'h69,
		SEI     = 8'h78,
		DEY     = 8'h88,
		TXA     = 8'h8A,
		TYA     = 8'h98,
		LDY_IMM = 8'hA0,
		LDX_IMM = 8'hA2,
		TAY     = 8'hA8,
		LDA_IMM = 8'hA9,
		TAX     = 8'hAA,
		CLV     = 8'hB8,
		CPY_IMM = 8'hC0,
		INY     = 8'hC8,
		CMP_IMM = 8'hC9,
		DEX     = 8'hCA,
		CLD     = 8'hD8,
		CPX_IMM = 8'hE0,
		INX     = 8'hE8,
		SBC_IMM = 8'hE9,
		NOP     = 8'hEA,
		SED     = 8'hF8
	} opcodeE;

	// Flag layout of P, bit 7 first
	typedef struct packed
	{
		logic n;
		logic v;
		logic one;
		logic b;
		logic d;
		logic i;
		logic z;
		logic c;
	} statusFlagsS;

	// P seen as a whole byte or as single flags
	typedef union packed
	{
		logic [7:0] raw;
		statusFlagsS flags;
	} statusU;

endpackage

// ==== cpu_uop_pkg.sv ====
`include "cpu_consts.svh"

package cpu_uop_pkg;

	// Operation done by execute
	typedef enum logic [3:0]
	{
		PASS,
		ADC,
		SBC,
		AND,
		ORA,
		EOR,
		CMP,
		INC,
		DEC,
		FLAG,
		NOP,
		HALT
	} aluOpE;

	// Register used as source or destination
	typedef enum logic [1:0]
	{
		A,
		X,
		Y,
		NONE
	} regSelE;

	// One decoded instruction
	typedef struct packed
	{
		aluOpE aluOp;
		regSelE srcReg;
		regSelE dstReg;
		logic useImm;
		logic [`CPU_DATA_W-1:0] imm;
		// Opcode bits 7..5 of set/clear instructions
		logic [2:0] flagSel;
	} uopS;

endpackage

// ==== cpu_fetch_decode.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_fetch_decode
(
	input logic Clk,
	input logic Res_n_i,
	input logic [`CPU_DATA_W-1:0] wbDat_i,
	input logic wbAck_i,
	input logic queueFull_i,
	output logic wbCyc_o,
	output logic wbStb_o,
	output logic [`CPU_ADDR_W-1:0] wbAdr_o,
	output logic pushValid_o,
	output cpu_uop_pkg::uopS pushUop_o
);

	typedef enum logic [1:0] {FETCH_OP, FETCH_IMM, STOPPED} fetchStateE;

	fetchStateE state;
	logic busActive;
	logic ackSeen;
	logic startCycle;
	logic [`CPU_ADDR_W-1:0] fetchAdr;
	logic [`CPU_DATA_W-1:0] opReg;
	logic [`CPU_DATA_W-1:0] opSel;

	// Opcode and operand byte to micro-op
	function automatic cpu_uop_pkg::uopS decodeOp(input logic [`CPU_DATA_W-1:0] opByte,
		input logic [`CPU_DATA_W-1:0] immByte);
		cpu_uop_pkg::uopS uop;
		// Default is a one-byte no-op
		uop.aluOp = cpu_uop_pkg::NOP;
		uop.srcReg = cpu_uop_pkg::NONE;
		uop.dstReg = cpu_uop_pkg::NONE;
		uop.useImm = 1'b0;
		uop.imm = immByte;
		uop.flagSel = opByte[7:5];
		case (opByte)
			cpu_isa_pkg::LDA_IMM:
			begin
				uop.aluOp = cpu_uop_pkg::PASS;
				uop.dstReg = cpu_uop_pkg::A;
				uop.useImm = 1'b1;
			end
			cpu_isa_pkg::LDX_IMM:
			begin
				uop.aluOp = cpu_uop_pkg::PASS;
				uop.dstReg = cpu_uop_pkg::X;
				uop.useImm = 1'b1;
			end
			cpu_isa_pkg::LDY_IMM:
			begin
				uop.aluOp = cpu_uop_pkg::PASS;
				uop.dstReg = cpu_uop_pkg::Y;
				uop.useImm = 1'b1;
			end
			// Accumulator arithmetic and logic
			cpu_isa_pkg::ADC_IMM, cpu_isa_pkg::SBC_IMM, cpu_isa_pkg::AND_IMM,
			cpu_isa_pkg::ORA_IMM, cpu_isa_pkg::EOR_IMM:
			begin
				case (opByte)
					cpu_isa_pkg::ADC_IMM: uop.aluOp = cpu_uop_pkg::ADC;
					cpu_isa_pkg::SBC_IMM: uop.aluOp = cpu_uop_pkg::SBC;
					cpu_isa_pkg::AND_IMM: uop.aluOp = cpu_uop_pkg::AND;
					cpu_isa_pkg::ORA_IMM: uop.aluOp = cpu_uop_pkg::ORA;
					default: uop.aluOp = cpu_uop_pkg::EOR;
				endcase
				uop.srcReg = cpu_uop_pkg::A;
				uop.dstReg = cpu_uop_pkg::A;
				uop.useImm = 1'b1;
			end
			// Compares write no register
			cpu_isa_pkg::CMP_IMM, cpu_isa_pkg::CPX_IMM, cpu_isa_pkg::CPY_IMM:
			begin
				uop.aluOp = cpu_uop_pkg::CMP;
				uop.useImm = 1'b1;
				case (opByte)
					cpu_isa_pkg::CPX_IMM: uop.srcReg = cpu_uop_pkg::X;
					cpu_isa_pkg::CPY_IMM: uop.srcReg = cpu_uop_pkg::Y;
					default: uop.srcReg = cpu_uop_pkg::A;
				endcase
			end
			cpu_isa_pkg::TAX, cpu_isa_pkg::TAY:
			begin
				uop.aluOp = cpu_uop_pkg::PASS;
				uop.srcReg = cpu_uop_pkg::A;
				uop.dstReg = (opByte == cpu_isa_pkg::TAX) ? cpu_uop_pkg::X : cpu_uop_pkg::Y;
			end
			cpu_isa_pkg::TXA, cpu_isa_pkg::TYA:
			begin
				uop.aluOp = cpu_uop_pkg::PASS;
				uop.srcReg = (opByte == cpu_isa_pkg::TXA) ? cpu_uop_pkg::X : cpu_uop_pkg::Y;
				uop.dstReg = cpu_uop_pkg::A;
			end
			// Index increments and decrements work in place
			cpu_isa_pkg::INX, cpu_isa_pkg::DEX:
			begin
				uop.aluOp = (opByte == cpu_isa_pkg::INX) ? cpu_uop_pkg::INC : cpu_uop_pkg::DEC;
				uop.srcReg = cpu_uop_pkg::X;
				uop.dstReg = cpu_uop_pkg::X;
			end
			cpu_isa_pkg::INY, cpu_isa_pkg::DEY:
			begin
				uop.aluOp = (opByte == cpu_isa_pkg::INY) ? cpu_uop_pkg::INC : cpu_uop_pkg::DEC;
				uop.srcReg = cpu_uop_pkg::Y;
				uop.dstReg = cpu_uop_pkg::Y;
			end
			cpu_isa_pkg::CLC, cpu_isa_pkg::SEC, cpu_isa_pkg::CLI, cpu_isa_pkg::SEI,
			cpu_isa_pkg::CLV, cpu_isa_pkg::CLD, cpu_isa_pkg::SED:
				uop.aluOp = cpu_uop_pkg::FLAG;
			cpu_isa_pkg::BRK:
				uop.aluOp = cpu_uop_pkg::HALT;
			default: ;
		endcase
		return uop;
	endfunction

	// One Wishbone cycle at a time
	assign wbCyc_o = busActive;
	assign wbStb_o = busActive;
	assign wbAdr_o = fetchAdr;
	assign ackSeen = busActive && wbAck_i;

	// A new instruction only starts when the queue has room
	// Its operand then always finds the slot free
	assign startCycle = !busActive &&
		((state == FETCH_OP && !queueFull_i) || state == FETCH_IMM);

	// Operand phase decodes the latched opcode
	assign opSel = (state == FETCH_IMM) ? opReg : wbDat_i;
	assign pushUop_o = decodeOp(opSel, wbDat_i);

	// Push on the last byte of an instruction
	assign pushValid_o = ackSeen && (state == FETCH_IMM || !pushUop_o.useImm);

	always_ff @(posedge Clk or negedge Res_n_i)
	begin
		if (!Res_n_i)
		begin
			state <= FETCH_OP;
			busActive <= 1'b0;
			fetchAdr <= `CPU_START_PC;
		end
		else
		begin
			if (ackSeen)
			begin
				// Strobe drops for at least one cycle
				busActive <= 1'b0;
				fetchAdr <= fetchAdr + 1'b1;
				case (state)
					FETCH_OP:
					begin
						if (pushUop_o.aluOp == cpu_uop_pkg::HALT)
							state <= STOPPED;
						else if (pushUop_o.useImm)
							state <= FETCH_IMM;
					end
					FETCH_IMM: state <= FETCH_OP;
					default: ;
				endcase
			end
			else if (startCycle)
			begin
				busActive <= 1'b1;
			end
		end
	end

	// Opcode kept for the operand phase
	always_ff @(posedge Clk)
	begin
		if (ackSeen && state == FETCH_OP)
			opReg <= wbDat_i;
	end

endmodule

// ==== cpu_uop_queue.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_uop_queue
#(
	parameter int Depth = `CPU_UOP_DEPTH
)
(
	input logic Clk,
	input logic Res_n_i,
	input logic pushValid_i,
	input cpu_uop_pkg::uopS pushUop_i,
	input logic pop_i,
	output logic queueFull_o,
	output logic headValid_o,
	output cpu_uop_pkg::uopS headUop_o
);

	localparam int PtrW = $clog2(Depth);
	localparam int CntW = PtrW + 1;

	cpu_uop_pkg::uopS mem [Depth];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CntW-1:0] count;
	logic doPush;
	logic doPop;

	// Status from the fill count
	assign queueFull_o = (count == Depth);
	assign headValid_o = (count != 0);
	assign headUop_o = mem[rdPtr];

	assign doPush = pushValid_i && !queueFull_o;
	assign doPop = pop_i && headValid_o;

	// Pointers wrap on their own for a power-of-two depth
	always_ff @(posedge Clk or negedge Res_n_i)
	begin
		if (!Res_n_i)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge Clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushUop_i;
	end

endmodule

// ==== cpu_execute.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_execute
(
	input logic Clk,
	input logic Res_n_i,
	input logic headValid_i,
	input cpu_uop_pkg::uopS headUop_i,
	output logic pop_o,
	output logic retire_o,
	output logic [`CPU_DATA_W-1:0] regA_o,
	output logic [`CPU_DATA_W-1:0] regX_o,
	output logic [`CPU_DATA_W-1:0] regY_o,
	output logic [7:0] regP_o,
	output logic halted_o
);

	cpu_isa_pkg::statusU regP;
	cpu_isa_pkg::statusU nextP;
	logic [`CPU_DATA_W-1:0] srcVal;
	logic [`CPU_DATA_W-1:0] addB;
	logic [`CPU_DATA_W-1:0] result;
	logic [`CPU_DATA_W:0] sum;
	logic carryIn;

	// Take every valid head until halted
	assign pop_o = headValid_i && !halted_o;
	assign regP_o = regP.raw;

	always_comb
	begin
		case (headUop_i.srcReg)
			cpu_uop_pkg::A: srcVal = regA_o;
			cpu_uop_pkg::X: srcVal = regX_o;
			cpu_uop_pkg::Y: srcVal = regY_o;
			default: srcVal = '0;
		endcase

		// Shared adder
		// SBC and compare add the inverted operand
		// Compare always carries in
		addB = headUop_i.imm;
		if (headUop_i.aluOp == cpu_uop_pkg::SBC || headUop_i.aluOp == cpu_uop_pkg::CMP)
			addB = ~headUop_i.imm;
		carryIn = (headUop_i.aluOp == cpu_uop_pkg::CMP) ? 1'b1 : regP.flags.c;
		sum = {1'b0, srcVal} + {1'b0, addB} + {{`CPU_DATA_W{1'b0}}, carryIn};

		case (headUop_i.aluOp)
			cpu_uop_pkg::PASS: result = headUop_i.useImm ? headUop_i.imm : srcVal;
			cpu_uop_pkg::AND: result = srcVal & headUop_i.imm;
			cpu_uop_pkg::ORA: result = srcVal | headUop_i.imm;
			cpu_uop_pkg::EOR: result = srcVal ^ headUop_i.imm;
			cpu_uop_pkg::INC: result = srcVal + 1'b1;
			cpu_uop_pkg::DEC: result = srcVal - 1'b1;
			cpu_uop_pkg::ADC, cpu_uop_pkg::SBC, cpu_uop_pkg::CMP: result = sum[`CPU_DATA_W-1:0];
			default: result = srcVal;
		endcase

		nextP = regP;
		case (headUop_i.aluOp)
			cpu_uop_pkg::ADC, cpu_uop_pkg::SBC:
			begin
				nextP.flags.c = sum[`CPU_DATA_W];
				// Same operand signs but a different result sign
				nextP.flags.v = (srcVal[7] == addB[7]) && (result[7] != srcVal[7]);
			end
			// Carry out means register >= operand
			cpu_uop_pkg::CMP: nextP.flags.c = sum[`CPU_DATA_W];
			// Set and clear as on the 6502
			cpu_uop_pkg::FLAG:
				case (headUop_i.flagSel)
					3'b000: nextP.flags.c = 1'b0;
					3'b001: nextP.flags.c = 1'b1;
					3'b010: nextP.flags.i = 1'b0;
					3'b011: nextP.flags.i = 1'b1;
					3'b101: nextP.flags.v = 1'b0;
					3'b110: nextP.flags.d = 1'b0;
					3'b111: nextP.flags.d = 1'b1;
					default: ;
				endcase
			default: ;
		endcase

		// N and Z follow every result
		if (headUop_i.aluOp inside {cpu_uop_pkg::PASS, cpu_uop_pkg::ADC, cpu_uop_pkg::SBC,
			cpu_uop_pkg::AND, cpu_uop_pkg::ORA, cpu_uop_pkg::EOR, cpu_uop_pkg::CMP,
			cpu_uop_pkg::INC, cpu_uop_pkg::DEC})
		begin
			nextP.flags.n = result[7];
			nextP.flags.z = (result == '0);
		end

		// These two bits always read 1
		nextP.flags.b = 1'b1;
		nextP.flags.one = 1'b1;
	end

	always_ff @(posedge Clk or negedge Res_n_i)
	begin
		if (!Res_n_i)
		begin
			regA_o <= '0;
			regX_o <= '0;
			regY_o <= '0;
			regP.raw <= `CPU_P_RESET;
			retire_o <= 1'b0;
			halted_o <= 1'b0;
		end
		else
		begin
			retire_o <= 1'b0;
			if (pop_o)
			begin
				// NONE as destination writes nothing
				case (headUop_i.dstReg)
					cpu_uop_pkg::A: regA_o <= result;
					cpu_uop_pkg::X: regX_o <= result;
					cpu_uop_pkg::Y: regY_o <= result;
					default: ;
				endcase
				regP <= nextP;
				// HALT stops instead of retiring
				if (headUop_i.aluOp == cpu_uop_pkg::HALT)
					halted_o <= 1'b1;
				else
					retire_o <= 1'b1;
			end
		end
	end

endmodule

// ==== cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_core
(
	input logic Clk,
	input logic Res_n_i,
	output logic wbCyc_o,
	output logic wbStb_o,
	output logic [`CPU_ADDR_W-1:0] wbAdr_o,
	input logic [`CPU_DATA_W-1:0] wbDat_i,
	input logic wbAck_i,
	output logic retire_o,
	output logic [`CPU_DATA_W-1:0] regA_o,
	output logic [`CPU_DATA_W-1:0] regX_o,
	output logic [`CPU_DATA_W-1:0] regY_o,
	output logic [7:0] regP_o,
	output logic halted_o
);

	// Fetch to queue
	logic pushValid;
	cpu_uop_pkg::uopS pushUop;
	logic queueFull;

	// Queue to execute
	logic headValid;
	cpu_uop_pkg::uopS headUop;
	logic pop;

	// Producer
	cpu_fetch_decode fetchDecode
	(
		.Clk(Clk),
		.Res_n_i(Res_n_i),
		.wbDat_i(wbDat_i),
		.wbAck_i(wbAck_i),
		.queueFull_i(queueFull),
		.wbCyc_o(wbCyc_o),
		.wbStb_o(wbStb_o),
		.wbAdr_o(wbAdr_o),
		.pushValid_o(pushValid),
		.pushUop_o(pushUop)
	);

	// Decoded instructions wait here
	cpu_uop_queue #(.Depth(`CPU_UOP_DEPTH)) uopQueue
	(
		.Clk(Clk),
		.Res_n_i(Res_n_i),
		.pushValid_i(pushValid),
		.pushUop_i(pushUop),
		.pop_i(pop),
		.queueFull_o(queueFull),
		.headValid_o(headValid),
		.headUop_o(headUop)
	);

	// Consumer
	cpu_execute execute
	(
		.Clk(Clk),
		.Res_n_i(Res_n_i),
		.headValid_i(headValid),
		.headUop_i(headUop),
		.pop_o(pop),
		.retire_o(retire_o),
		.regA_o(regA_o),
		.regX_o(regX_o),
		.regY_o(regY_o),
		.regP_o(regP_o),
		.halted_o(halted_o)
	);

endmodule

// ==== tb_cpu_assertions.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_cpu_assertions
(
	input logic Clk,
	input logic Res_n_i,
	input logic wbCyc_i,
	input logic wbStb_i,
	input logic [`CPU_ADDR_W-1:0] wbAdr_i,
	input logic wbAck_i,
	input logic pushValid_i,
	input logic queueFull_i,
	input logic retire_i,
	input logic halted_i
);

	// Classic bus never strobes outside a cycle
	assert property (@(posedge Clk) disable iff (!Res_n_i) wbStb_i |-> wbCyc_i)
		else $error("wbStb_o high without wbCyc_o");

	// Waiting strobe holds its address
	assert property (@(posedge Clk) disable iff (!Res_n_i)
		(wbStb_i && !wbAck_i) |=> (wbStb_i && $stable(wbAdr_i)))
		else $error("wbStb_o or wbAdr_o changed before acknowledge");

	// Fetch must hold back when the queue has no room
	assert property (@(posedge Clk) disable iff (!Res_n_i) queueFull_i |-> !pushValid_i)
		else $error("micro-op pushed into a full queue");

	// Halted core retires nothing
	assert property (@(posedge Clk) disable iff (!Res_n_i) halted_i |-> !retire_i)
		else $error("retire_o pulsed after halted_o");

endmodule

// ==== tb_cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_cpu_core;

	logic Clk = 1'b0;
	logic resN;
	logic wbCyc;
	logic wbStb;
	logic [`CPU_ADDR_W-1:0] wbAdr;
	logic [`CPU_DATA_W-1:0] wbDat;
	logic wbAck;
	logic retire;
	logic [7:0] regA;
	logic [7:0] regX;
	logic [7:0] regY;
	logic [7:0] regP;
	logic halted;

	// Byte memory behind the bus
	logic [7:0] mem [0:65535];
	logic [1:0] waitCnt;

	// Expected {A, X, Y, P} per retirement
	logic [31:0] expected [$];
	logic haltExpected = 1'b0;
	logic traceLoaded = 1'b0;
	int retireCount = 0;

	cpu_core DUT
	(
		.Clk(Clk),
		.Res_n_i(resN),
		.wbCyc_o(wbCyc),
		.wbStb_o(wbStb),
		.wbAdr_o(wbAdr),
		.wbDat_i(wbDat),
		.wbAck_i(wbAck),
		.retire_o(retire),
		.regA_o(regA),
		.regX_o(regX),
		.regY_o(regY),
		.regP_o(regP),
		.halted_o(halted)
	);

	bind cpu_core tb_cpu_assertions busChecks
	(
		.Clk(Clk),
		.Res_n_i(Res_n_i),
		.wbCyc_i(wbCyc_o),
		.wbStb_i(wbStb_o),
		.wbAdr_i(wbAdr_o),
		.wbAck_i(wbAck_i),
		.pushValid_i(pushValid),
		.queueFull_i(queueFull),
		.retire_i(retire_o),
		.halted_i(halted_o)
	);

	// 20 ns period
	always #10 Clk = ~Clk;

	// Prints the reason and stops at the first error
	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic compareValue(input string name, input logic [15:0] expVal,
		input logic [15:0] actual);
		if (actual !== expVal)
			stopRun($sformatf("mismatch %s: expected 0x%h, got 0x%h at retirement %0d",
				name, expVal, actual, retireCount));
	endtask

	// M lines load bytes, R lines queue records, H asks for a halt
	task automatic readTrace();
		int fd;
		int fields;
		string line;
		logic [15:0] loadAdr;
		logic [7:0] progBytes [8];
		logic [7:0] recA;
		logic [7:0] recX;
		logic [7:0] recY;
		logic [7:0] recP;
		fd = $fopen("cpu_trace.txt", "r");
		if (fd == 0)
			stopRun("cannot open trace file cpu_trace.txt");
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() == 0)
				continue;
			if (line[0] == "M")
			begin
				fields = $sscanf(line, "M %h %h %h %h %h %h %h %h %h", loadAdr,
					progBytes[0], progBytes[1], progBytes[2], progBytes[3],
					progBytes[4], progBytes[5], progBytes[6], progBytes[7]);
				if (fields < 2)
					stopRun("malformed memory line in trace file");
				for (int k = 1; k < fields; k++)
					mem[loadAdr + k - 1] = progBytes[k - 1];
			end
			else if (line[0] == "R")
			begin
				if ($sscanf(line, "R %h %h %h %h", recA, recX, recY, recP) != 4)
					stopRun("malformed register line in trace file");
				expected.push_back({recA, recX, recY, recP});
			end
			else if (line[0] == "H")
				haltExpected = 1'b1;
		end
		$fclose(fd);
	endtask

	// Slave answers each strobe after 0 to 3 wait cycles
	always @(posedge Clk or negedge resN)
	begin
		if (!resN)
		begin
			wbAck <= 1'b0;
			wbDat <= '0;
			waitCnt <= '0;
		end
		else
		begin
			wbAck <= 1'b0;
			if (wbStb && !wbAck)
			begin
				if (waitCnt == 0)
				begin
					wbAck <= 1'b1;
					wbDat <= mem[wbAdr];
					waitCnt <= $urandom % 4;
				end
				else
					waitCnt <= waitCnt - 1'b1;
			end
		end
	end

	initial
	begin
		logic [31:0] rec;
		logic strobeSeen;
		void'($urandom(32'hf193_a3ab));
		resN = 1'b0;
		wbAck = 1'b0;
		wbDat = '0;
		strobeSeen = 1'b0;
		// Filler depends on every address bit
		for (int i = 0; i < 65536; i++)
			mem[i] = i[7:0] ^ i[15:8] ^ 8'h5A;
		readTrace();
		if (!haltExpected)
			stopRun("trace file has no halt record");
		traceLoaded = 1'b1;

		repeat (16) @(posedge Clk);
		resN <= 1'b1;

		// Reset values
		@(negedge Clk);
		compareValue("regA_o", 8'h00, regA);
		compareValue("regX_o", 8'h00, regX);
		compareValue("regY_o", 8'h00, regY);
		compareValue("regP_o", 8'h34, regP);
		compareValue("halted_o", 1'b0, halted);
		compareValue("wbCyc_o", 1'b0, wbCyc);
		compareValue("wbStb_o", 1'b0, wbStb);
		compareValue("retire_o", 1'b0, retire);

		// Sampled at the falling edge where outputs are settled
		while (!halted)
		begin
			if (wbStb && !strobeSeen)
			begin
				strobeSeen = 1'b1;
				compareValue("wbAdr_o", 16'h0200, wbAdr);
			end
			if (retire)
			begin
				if (retireCount >= expected.size())
					stopRun("retirement beyond the last trace record");
				rec = expected[retireCount];
				compareValue("regA_o", rec[31:24], regA);
				compareValue("regX_o", rec[23:16], regX);
				compareValue("regY_o", rec[15:8], regY);
				compareValue("regP_o", rec[7:0], regP);
				retireCount++;
			end
			@(negedge Clk);
		end

		if (retireCount != expected.size())
			stopRun($sformatf("halted after %0d retirements, trace expects %0d",
				retireCount, expected.size()));

		// Core stays quiet once halted
		repeat (20)
		begin
			if (retire)
				stopRun("retirement after halt");
			compareValue("wbCyc_o", 1'b0, wbCyc);
			compareValue("wbStb_o", 1'b0, wbStb);
			@(negedge Clk);
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

	// Budget of 40 cycles per record
	initial
	begin
		wait (traceLoaded);
		repeat (expected.size() * 40 + 200) @(posedge Clk);
		stopRun($sformatf("watchdog expired, no halt after %0d of %0d retirements",
			retireCount, expected.size()));
	end

endmodule

// ==== cpu_trace.txt ====
# M <addr> <byte> ...  program bytes placed from addr upward, hex
# R <A> <X> <Y> <P>    registers after each retired instruction, hex; H means BRK must halt
M 0200 A9 00 A2 FF E8 A0 80 88
M 0208 A9 50 AA 69 50 B8 A9 FF
M 0210 69 01 A9 10 E9 05 18 E9
M 0218 0B 29 0F 09 80 49 8F A8
M 0220 8A C9 50 E0 60 C8 C0 00
M 0228 98 58 78 F8 D8 18 38 EA
M 0230 FF CA E8 E8 E8 E8 88 00
R 00 00 00 36  LDA #$00
R 00 FF 00 B4  LDX #$FF
R 00 00 00 36  INX wraps to zero
R 00 00 80 B4  LDY #$80
R 00 00 7F 34  DEY
R 50 00 7F 34  LDA #$50
R 50 50 7F 34  TAX
R A0 50 7F F4  ADC #$50 overflow
R A0 50 7F B4  CLV
R FF 50 7F B4  LDA #$FF
R 00 50 7F 37  ADC #$01 carry and zero
R 10 50 7F 35  LDA #$10
R 0B 50 7F 35  SBC #$05 no borrow
R 0B 50 7F 34  CLC
R FF 50 7F B4  SBC #$0B with borrow
R 0F 50 7F 34  AND #$0F
R 8F 50 7F B4  ORA #$80
R 00 50 7F 36  EOR #$8F
R 00 50 00 36  TAY
R 50 50 00 34  TXA
R 50 50 00 37  CMP #$50 equal
R 50 50 00 B4  CPX #$60 below
R 50 50 01 34  INY
R 50 50 01 35  CPY #$00 above
R 01 50 01 35  TYA
R 01 50 01 31  CLI
R 01 50 01 35  SEI
R 01 50 01 3D  SED
R 01 50 01 35  CLD
R 01 50 01 34  CLC
R 01 50 01 35  SEC
R 01 50 01 35  NOP
R 01 50 01 35  unknown opcode $FF
R 01 4F 01 35  DEX
R 01 50 01 35  INX
R 01 51 01 35  INX
R 01 52 01 35  INX
R 01 53 01 35  INX
R 01 53 00 37  DEY
H

// ==== build.f ====
+incdir+.
cpu_isa_pkg.sv
cpu_uop_pkg.sv
cpu_fetch_decode.sv
cpu_uop_queue.sv
cpu_execute.sv
cpu_core.sv
tb_cpu_assertions.sv
tb_cpu_core.sv

// ==== Bender.yml ====
package:
  name: cpu_core

export_include_dirs:
  - .

sources:
  - files:
      - cpu_isa_pkg.sv
      - cpu_uop_pkg.sv
      - cpu_fetch_decode.sv
      - cpu_uop_queue.sv
      - cpu_execute.sv
      - cpu_core.sv
  - target: test
    files:
      - tb_cpu_assertions.sv
      - tb_cpu_core.sv
